// ==== sources.f ====
+incdir+tb
hdl/eth_tx_pkg.sv
hdl/payload_fifo.sv
hdl/frame_header_gen.sv
hdl/fcs_crc32.sv
hdl/mac_tx.sv
hdl/udp_tx_top.sv
tb/tb_udp_tx.sv

// ==== Makefile ====
TOP := tb_udp_tx

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf obj_dir

// ==== tb/frame_model.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the transmitted frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Right-shift Galois LFSR for x^32 + x^22 + x^2 + x + 1.
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

// Normal (MSB first) CRC-32 register fed with the bits of each byte LSB first.
function automatic crc_t crc32_byte(input crc_t c, input byte_t b);
    crc_t r;
    r = c;
    for (int i = 0; i < 8; i++) begin
        if (r[31] ^ b[i]) begin
            r = (r << 1) ^ 32'h04C1_1DB7;
        end else begin
            r = r << 1;
        end
    end
    return r;
endfunction

// The wire order of the FCS is the bit reversed complement.
function automatic crc_t crc32_final(input crc_t c);
    crc_t r;
    for (int i = 0; i < 32; i++) begin
        r[i] = ~c[31 - i];
    end
    return r;
endfunction

function automatic byte_t header_byte(input frame_header_t h, input int pos);
    return h[(HEADER_BYTES - 1 - pos) * 8 +: 8];
endfunction

// Writes n bytes of v, most significant first, starting at byte pos.
function automatic frame_header_t put_bytes(input frame_header_t h, input int pos,
                                            input int n, input logic [47:0] v);
    frame_header_t r;
    r = h;
    for (int i = 0; i < n; i++) begin
        r[(HEADER_BYTES - 1 - pos - i) * 8 +: 8] = v[(n - 1 - i) * 8 +: 8];
    end
    return r;
endfunction

// Ones' complement sum over the ten words of the IPv4 header.
function automatic logic [15:0] ipv4_checksum(input frame_header_t h);
    logic [31:0] sum;
    sum = '0;
    for (int j = 0; j < 10; j++) begin
        sum = sum + {16'h0, header_byte(h, 14 + 2 * j), header_byte(h, 15 + 2 * j)};
    end
    while (sum[31:16] != 16'h0) begin
        sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
    end
    return ~sum[15:0];
endfunction

function automatic frame_header_t model_header(input int n, input endpoint_t fpga,
                                               input endpoint_t host);
    frame_header_t h;
    h = '0;
    h = put_bytes(h, 0, 6, host.mac);
    h = put_bytes(h, 6, 6, fpga.mac);
    h = put_bytes(h, 12, 2, 48'(ETHERTYPE_IPV4));
    h = put_bytes(h, 14, 2, 48'h4500);
    h = put_bytes(h, 16, 2, 48'(n + 28));
    h = put_bytes(h, 20, 2, 48'h4000);
    h = put_bytes(h, 22, 1, 48'(IP_TTL));
    h = put_bytes(h, 23, 1, 48'(IP_PROTO_UDP));
    h = put_bytes(h, 26, 4, 48'(fpga.ip));
    h = put_bytes(h, 30, 4, 48'(host.ip));
    h = put_bytes(h, 34, 2, 48'(fpga.port));
    h = put_bytes(h, 36, 2, 48'(host.port));
    h = put_bytes(h, 38, 2, 48'(n + 8));
    h = put_bytes(h, 24, 2, 48'(ipv4_checksum(h)));
    return h;
endfunction

// ==== tb/tb_udp_tx.sv ====
`timescale 1ns/1ns

module tb_udp_tx;
    import eth_tx_pkg::*;

    `include "frame_model.svh"

    localparam int PAYLOAD_W  = 11;
    localparam int FIFO_AW    = 8;
    localparam int FIFO_DEPTH = 2 ** FIFO_AW;
    localparam int NUM_FRAMES = 5;
    localparam int MAX_BYTES  = 1024;

    localparam endpoint_t FPGA_A = '{mac: 48'h02_0A_35_00_00_01, ip: 32'hC0A8_0A02, port: 16'd1234};
    localparam endpoint_t FPGA_B = '{mac: 48'h02_0A_35_7F_EE_10, ip: 32'h0A00_0017, port: 16'hFFFE};
    localparam endpoint_t HOST_A = '{mac: 48'h00_1B_21_3A_4C_5D, ip: 32'hC0A8_0A01, port: 16'd5678};
    localparam endpoint_t HOST_B = '{mac: 48'hFF_FF_FF_FF_FF_FF, ip: 32'hFFFF_FF01, port: 16'd53};

    typedef struct packed {
        logic [PAYLOAD_W-1:0] len;
        endpoint_t            fpga;
        endpoint_t            host;
        logic [1:0]           gap_mode;
    } frame_row_t;

    logic                 clk_i;
    logic                 rst_i;
    byte_t                s_data_i;
    logic                 s_valid_i;
    logic                 s_ready_o;
    logic [PAYLOAD_W-1:0] payload_len_i;
    endpoint_t            fpga_ep_i;
    endpoint_t            host_ep_i;
    logic                 tx_en_o;
    byte_t                tx_d_o;

    frame_row_t  rows [NUM_FRAMES];
    int          cum_start [NUM_FRAMES];
    int          cum_end [NUM_FRAMES];
    byte_t       payload [MAX_BYTES];
    int          total_bytes;
    int          limit_cycles;
    logic [31:0] lfsr_q;
    int          feed_idx;
    int          accepted_cnt;
    logic        stall_seen;
    byte_t       burst [$];
    logic        in_burst;
    int          frame_idx;
    int          low_cycles;
    int          cycle_cnt;

    udp_tx_top #(
        .PAYLOAD_WIDTH  (PAYLOAD_W),
        .FIFO_ADDR_WIDTH(FIFO_AW)
    ) dut0 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .s_data_i     (s_data_i),
        .s_valid_i    (s_valid_i),
        .s_ready_o    (s_ready_o),
        .payload_len_i(payload_len_i),
        .fpga_ep_i    (fpga_ep_i),
        .host_ep_i    (host_ep_i),
        .tx_en_o      (tx_en_o),
        .tx_d_o       (tx_d_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp, input string name);
        if (got !== exp) begin
            fail_now($sformatf("ERROR %0t ns %s got %02h expected %02h", $time, name, got, exp));
        end
    endtask

    task automatic check_crc(input crc_t got, input crc_t exp, input string name);
        if (got !== exp) begin
            fail_now($sformatf("ERROR %0t ns %s got %08h expected %08h", $time, name, got, exp));
        end
    endtask

    task automatic check_length(input int got, input int exp, input string name);
        if (got != exp) begin
            fail_now($sformatf("ERROR %0t ns %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_q[0];
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    function automatic int row_of(input int idx);
        int r;
        r = 0;
        while (r < NUM_FRAMES - 1 && idx >= cum_end[r]) begin
            r++;
        end
        return r;
    endfunction

    // Mode 1 idles about half the cycles, mode 2 about a quarter.
    function automatic logic hold_off(input logic [1:0] mode);
        logic [7:0] r;
        if (mode == 2'd0) begin
            return 1'b0;
        end
        r = rand_bits(int'(mode));
        if (mode == 2'd1) begin
            return r[0];
        end
        return r[0] & r[1];
    endfunction

    task automatic check_frame(input int k);
        frame_header_t hdr;
        crc_t          crc;
        crc_t          got_crc;
        int            n;
        int            base;
        n    = int'(rows[k].len);
        hdr  = model_header(n, rows[k].fpga, rows[k].host);
        base = PREAMBLE_BYTES + SFD_BYTES;
        check_length(burst.size(), 54 + n, $sformatf("frame %0d tx_en_o length", k));
        for (int i = 0; i < PREAMBLE_BYTES; i++) begin
            check_byte(burst[i], PREAMBLE_VAL, $sformatf("frame %0d tx_d_o preamble", k));
        end
        check_byte(burst[PREAMBLE_BYTES], SFD_VAL, $sformatf("frame %0d tx_d_o sfd", k));
        crc = '1;
        for (int i = 0; i < HEADER_BYTES; i++) begin
            check_byte(burst[base + i], header_byte(hdr, i),
                       $sformatf("frame %0d tx_d_o header[%0d]", k, i));
            crc = crc32_byte(crc, header_byte(hdr, i));
        end
        base = base + HEADER_BYTES;
        for (int i = 0; i < n; i++) begin
            check_byte(burst[base + i], payload[cum_start[k] + i],
                       $sformatf("frame %0d tx_d_o payload[%0d]", k, i));
            crc = crc32_byte(crc, payload[cum_start[k] + i]);
        end
        base = base + n;
        got_crc = {burst[base + 3], burst[base + 2], burst[base + 1], burst[base]};
        check_crc(got_crc, crc32_final(crc), $sformatf("frame %0d tx_d_o fcs", k));
    endtask

    task automatic open_burst();
        if (frame_idx >= NUM_FRAMES) begin
            fail_now("tx_en_o rose again after the last frame of the table");
        end
        if (frame_idx > 0 && low_cycles < GAP_BYTES) begin
            fail_now($sformatf("only %0d idle cycles before frame %0d", low_cycles, frame_idx));
        end
        if (accepted_cnt < cum_end[frame_idx]) begin
            fail_now($sformatf("frame %0d started before its payload was accepted", frame_idx));
        end
        in_burst = 1'b1;
        burst.delete();
        // The frame on the wire must ignore the next row's inputs.
        if (frame_idx + 1 < NUM_FRAMES) begin
            payload_len_i <= rows[frame_idx + 1].len;
            fpga_ep_i     <= rows[frame_idx + 1].fpga;
            host_ep_i     <= rows[frame_idx + 1].host;
        end else begin
            payload_len_i <= '1;
            fpga_ep_i     <= ~rows[0].fpga;
            host_ep_i     <= ~rows[0].host;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus and capture
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        rst_i       <= 1'b1;
        s_data_i    <= '0;
        s_valid_i   <= 1'b0;
        lfsr_q      = 32'h83c7c40a;
        rows[0] = '{11'd1, FPGA_A, HOST_A, 2'd0};
        rows[1] = '{11'd18, FPGA_B, HOST_B, 2'd1};
        rows[2] = '{11'(FIFO_DEPTH), FPGA_A, HOST_B, 2'd2};
        rows[3] = '{11'd46, FPGA_B, HOST_A, 2'd1};
        rows[4] = '{11'd200, FPGA_A, HOST_A, 2'd0};
        total_bytes  = 0;
        limit_cycles = 0;
        for (int k = 0; k < NUM_FRAMES; k++) begin
            cum_start[k] = total_bytes;
            total_bytes  = total_bytes + int'(rows[k].len);
            cum_end[k]   = total_bytes;
            limit_cycles = limit_cycles + 54 + 3 * int'(rows[k].len) + 40;
        end
        for (int i = 0; i < total_bytes; i++) begin
            payload[i] = rand_bits(8);
        end
        payload_len_i <= rows[0].len;
        fpga_ep_i     <= rows[0].fpga;
        host_ep_i     <= rows[0].host;
        repeat (16) @(posedge clk_i);
        rst_i <= 1'b0;
        wait (frame_idx == NUM_FRAMES);
        repeat (GAP_BYTES + 8) @(posedge clk_i);
        if (stall_seen) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            fail_now("the input stream never saw s_ready_o low while valid");
        end
    end

    // Valid holds with its data until the byte is taken.
    always @(posedge clk_i) begin
        if (rst_i) begin
            feed_idx   = 0;
            stall_seen = 1'b0;
        end else begin
            if (s_valid_i && s_ready_o) begin
                feed_idx = feed_idx + 1;
            end
            if (s_valid_i && !s_ready_o) begin
                stall_seen = 1'b1;
            end else if (feed_idx >= total_bytes) begin
                s_valid_i <= 1'b0;
            end else if (hold_off(rows[row_of(feed_idx)].gap_mode)) begin
                s_valid_i <= 1'b0;
            end else begin
                s_valid_i <= 1'b1;
                s_data_i  <= payload[feed_idx];
            end
        end
    end

    always @(posedge clk_i) begin
        if (rst_i) begin
            accepted_cnt <= 0;
        end else if (s_valid_i && s_ready_o) begin
            accepted_cnt <= accepted_cnt + 1;
        end
    end

    always @(posedge clk_i) begin
        if (rst_i) begin
            in_burst   = 1'b0;
            frame_idx  = 0;
            low_cycles = 0;
        end else if (tx_en_o) begin
            if (!in_burst) begin
                open_burst();
            end
            burst.push_back(tx_d_o);
        end else begin
            if (in_burst) begin
                check_frame(frame_idx);
                frame_idx  = frame_idx + 1;
                in_burst   = 1'b0;
                low_cycles = 0;
            end
            low_cycles = low_cycles + 1;
        end
    end

    always @(posedge clk_i) begin
        if (rst_i) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
            if (cycle_cnt >= limit_cycles) begin
                fail_now($sformatf("timeout: frames not done after %0d cycles", limit_cycles));
            end
        end
    end

endmodule

// ==== hdl/udp_tx_top.sv ====
`timescale 1ns/1ns

module udp_tx_top #(
    parameter int PAYLOAD_WIDTH   = 11,
    parameter int FIFO_ADDR_WIDTH = 11
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  eth_tx_pkg::byte_t        s_data_i,
    input  logic                     s_valid_i,
    output logic                     s_ready_o,
    input  logic [PAYLOAD_WIDTH-1:0] payload_len_i,
    input  eth_tx_pkg::endpoint_t    fpga_ep_i,
    input  eth_tx_pkg::endpoint_t    host_ep_i,
    output logic                     tx_en_o,
    output eth_tx_pkg::byte_t        tx_d_o
);
    import eth_tx_pkg::*;

    byte_t                    fifo_data;
    logic                     fifo_valid;
    logic                     fifo_pop;
    logic [FIFO_ADDR_WIDTH:0] fifo_count;

    payload_fifo #(
        .FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)
    ) u_fifo (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .s_data_i (s_data_i),
        .s_valid_i(s_valid_i),
        .s_ready_o(s_ready_o),
        .pop_i    (fifo_pop),
        .data_o   (fifo_data),
        .valid_o  (fifo_valid),
        .count_o  (fifo_count)
    );

    mac_tx #(
        .PAYLOAD_WIDTH  (PAYLOAD_WIDTH),
        .FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)
    ) u_mac_tx (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .fifo_data_i  (fifo_data),
        .fifo_valid_i (fifo_valid),
        .fifo_count_i (fifo_count),
        .fifo_pop_o   (fifo_pop),
        .payload_len_i(payload_len_i),
        .fpga_ep_i    (fpga_ep_i),
        .host_ep_i    (host_ep_i),
        .tx_en_o      (tx_en_o),
        .tx_d_o       (tx_d_o)
    );

endmodule

// ==== hdl/mac_tx.sv ====
`timescale 1ns/1ns

module mac_tx #(
    parameter int PAYLOAD_WIDTH   = 11,
    parameter int FIFO_ADDR_WIDTH = 11
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  eth_tx_pkg::byte_t        fifo_data_i,
    input  logic                     fifo_valid_i,
    input  logic [FIFO_ADDR_WIDTH:0] fifo_count_i,
    output logic                     fifo_pop_o,
    input  logic [PAYLOAD_WIDTH-1:0] payload_len_i,
    input  eth_tx_pkg::endpoint_t    fpga_ep_i,
    input  eth_tx_pkg::endpoint_t    host_ep_i,
    output logic                     tx_en_o,
    output eth_tx_pkg::byte_t        tx_d_o
);
    import eth_tx_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        SFD,
        HEADER,
        DATA,
        FCS,
        GAP
    } tx_state_t;

    // Wide enough for the header as well as the longest payload.
    localparam int CNT_WIDTH = (PAYLOAD_WIDTH > 6) ? PAYLOAD_WIDTH : 6;

    tx_state_t                state_q;
    tx_state_t                state_next;
    logic [CNT_WIDTH-1:0]     state_cnt;
    logic                     start;
    logic [PAYLOAD_WIDTH-1:0] len_q;
    logic [PAYLOAD_WIDTH-1:0] len_last;
    endpoint_t                fpga_ep_q;
    endpoint_t                host_ep_q;
    frame_header_t            header;
    frame_header_t            header_sr;
    crc_t                     fcs;
    logic [23:0]              fcs_sr;
    logic                     hdr_load;
    byte_t                    tx_data;
    logic                     tx_valid;

    assign start    = (32'(fifo_count_i) >= 32'(payload_len_i)) && (payload_len_i != '0);
    assign len_last = len_q - 1'b1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_next = state_q;
        case (state_q)
            IDLE: begin
                if (start) begin
                    state_next = PREAMBLE;
                end
            end
            PREAMBLE: begin
                if (state_cnt == CNT_WIDTH'(PREAMBLE_BYTES - 1)) begin
                    state_next = SFD;
                end
            end
            SFD: begin
                if (state_cnt == CNT_WIDTH'(SFD_BYTES - 1)) begin
                    state_next = HEADER;
                end
            end
            HEADER: begin
                if (state_cnt == CNT_WIDTH'(HEADER_BYTES - 1)) begin
                    state_next = DATA;
                end
            end
            DATA: begin
                if (state_cnt == CNT_WIDTH'(len_last)) begin
                    state_next = FCS;
                end
            end
            FCS: begin
                if (state_cnt == CNT_WIDTH'(FCS_BYTES - 1)) begin
                    state_next = GAP;
                end
            end
            GAP: begin
                if (state_cnt == CNT_WIDTH'(GAP_BYTES - 1)) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= IDLE;
            state_cnt <= '0;
        end else begin
            state_q   <= state_next;
            state_cnt <= (state_q != state_next) ? '0 : state_cnt + 1'b1;
        end
    end

    // Per-frame inputs are frozen for the whole frame.
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start) begin
            len_q     <= payload_len_i;
            fpga_ep_q <= fpga_ep_i;
            host_ep_q <= host_ep_i;
        end
    end

    assign hdr_load = (state_q == PREAMBLE) && (state_cnt == '0);

    frame_header_gen #(
        .PAYLOAD_WIDTH(PAYLOAD_WIDTH)
    ) u_header_gen (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .load_i       (hdr_load),
        .payload_len_i(len_q),
        .fpga_ep_i    (fpga_ep_q),
        .host_ep_i    (host_ep_q),
        .header_o     (header)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte select and output stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        tx_valid = 1'b1;
        tx_data  = '0;
        case (state_q)
            PREAMBLE: tx_data = PREAMBLE_VAL;
            SFD:      tx_data = SFD_VAL;
            HEADER:   tx_data = header_sr[$bits(frame_header_t)-1 -: 8];
            DATA: begin
                tx_valid = fifo_valid_i;
                tx_data  = fifo_data_i;
            end
            FCS:      tx_data = (state_cnt == '0) ? fcs[7:0] : fcs_sr[7:0];
            default:  tx_valid = 1'b0;
        endcase
    end

    assign fifo_pop_o = state_q == DATA;

    // The header is ready by SFD. The CRC holds still during FCS.
    always_ff @(posedge clk_i) begin
        if (state_q == SFD) begin
            header_sr <= header;
        end else if (state_q == HEADER) begin
            header_sr <= header_sr << 8;
        end
        if (state_q == FCS) begin
            fcs_sr <= (state_cnt == '0) ? fcs[31:8] : fcs_sr >> 8;
        end
    end

    fcs_crc32 u_fcs (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .clear_i(state_q == IDLE),
        .en_i   ((state_q == HEADER) || (state_q == DATA)),
        .data_i (tx_data),
        .crc_o  (fcs)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tx_en_o <= 1'b0;
        end else begin
            tx_en_o <= tx_valid;
        end
        tx_d_o <= tx_data;
    end

endmodule

// ==== hdl/fcs_crc32.sv ====
`timescale 1ns/1ns

module fcs_crc32 (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              clear_i,
    input  logic              en_i,
    input  eth_tx_pkg::byte_t data_i,
    output eth_tx_pkg::crc_t  crc_o
);
    import eth_tx_pkg::*;

    localparam crc_t POLY = 32'hEDB88320;

    crc_t crc_q;
    crc_t crc_next;

    // Reflected form, so the byte enters LSB first.
    always_comb begin
        crc_next = crc_q;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ data_i[i]) begin
                crc_next = (crc_next >> 1) ^ POLY;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            crc_q <= '1;
        end else if (en_i) begin
            crc_q <= crc_next;
        end
    end

    // Final inversion, low byte goes out first.
    assign crc_o = ~crc_q;

endmodule

// ==== hdl/frame_header_gen.sv ====
`timescale 1ns/1ns

module frame_header_gen #(
    parameter int PAYLOAD_WIDTH = 11
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      load_i,
    input  logic [PAYLOAD_WIDTH-1:0]  payload_len_i,
    input  eth_tx_pkg::endpoint_t     fpga_ep_i,
    input  eth_tx_pkg::endpoint_t     host_ep_i,
    output eth_tx_pkg::frame_header_t header_o
);
    import eth_tx_pkg::*;

    localparam logic [15:0] IP_VER_IHL_TOS = 16'h4500;
    localparam logic [15:0] IP_FLAGS_DF    = 16'h4000;
    localparam logic [15:0] IP_HDR_LEN     = 16'd20;
    localparam logic [15:0] UDP_HDR_LEN    = 16'd8;

    logic [15:0] udp_len;
    logic [15:0] ip_len;
    logic [15:0] ip_words [10];
    logic [19:0] word_sum;
    logic [16:0] fold_1;
    logic [15:0] fold_2;
    logic [15:0] ip_csum;

    assign udp_len = 16'(payload_len_i) + UDP_HDR_LEN;
    assign ip_len  = udp_len + IP_HDR_LEN;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // IPv4 header checksum
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The checksum field itself counts as zero.
    always_comb begin
        ip_words[0] = IP_VER_IHL_TOS;
        ip_words[1] = ip_len;
        ip_words[2] = 16'h0000;
        ip_words[3] = IP_FLAGS_DF;
        ip_words[4] = {IP_TTL, IP_PROTO_UDP};
        ip_words[5] = 16'h0000;
        ip_words[6] = fpga_ep_i.ip[31:16];
        ip_words[7] = fpga_ep_i.ip[15:0];
        ip_words[8] = host_ep_i.ip[31:16];
        ip_words[9] = host_ep_i.ip[15:0];
    end

    always_comb begin
        word_sum = '0;
        for (int i = 0; i < 10; i++) begin
            word_sum = word_sum + 20'(ip_words[i]);
        end
    end

    // Two end-around carry folds bring the sum back into 16 bits.
    assign fold_1  = {1'b0, word_sum[15:0]} + 17'(word_sum[19:16]);
    assign fold_2  = fold_1[15:0] + 16'(fold_1[16]);
    assign ip_csum = ~fold_2;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            header_o <= '0;
        end else if (load_i) begin
            header_o <= {
                host_ep_i.mac, fpga_ep_i.mac, ETHERTYPE_IPV4,
                IP_VER_IHL_TOS, ip_len, 16'h0000, IP_FLAGS_DF,
                IP_TTL, IP_PROTO_UDP, ip_csum,
                fpga_ep_i.ip, host_ep_i.ip,
                fpga_ep_i.port, host_ep_i.port, udp_len, 16'h0000
            };
        end
    end

endmodule

// ==== hdl/payload_fifo.sv ====
`timescale 1ns/1ns

module payload_fifo #(
    parameter int FIFO_ADDR_WIDTH = 11
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  eth_tx_pkg::byte_t        s_data_i,
    input  logic                     s_valid_i,
    output logic                     s_ready_o,
    input  logic                     pop_i,
    output eth_tx_pkg::byte_t        data_o,
    output logic                     valid_o,
    output logic [FIFO_ADDR_WIDTH:0] count_o
);
    import eth_tx_pkg::*;

    localparam int DEPTH = 2 ** FIFO_ADDR_WIDTH;

    byte_t                      mem [DEPTH];
    logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;
    logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;
    logic [FIFO_ADDR_WIDTH:0]   count_q;
    logic [FIFO_ADDR_WIDTH:0]   count_next;
    logic                       ready_q;
    logic                       push;
    logic                       pop;

    assign push = s_valid_i && ready_q;
    assign pop  = pop_i && valid_o;

    always_comb begin
        count_next = count_q;
        if (push && !pop) begin
            count_next = count_q + 1'b1;
        end else if (pop && !push) begin
            count_next = count_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
            ready_q <= 1'b0;
        end else begin
            wr_ptr  <= push ? wr_ptr + 1'b1 : wr_ptr;
            rd_ptr  <= pop ? rd_ptr + 1'b1 : rd_ptr;
            count_q <= count_next;
            // Ready drops in the cycle after the last free slot is taken.
            ready_q <= count_next != (FIFO_ADDR_WIDTH + 1)'(DEPTH);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= s_data_i;
        end
    end

    // First word fall through: the head byte is always on the output.
    assign data_o    = mem[rd_ptr];
    assign valid_o   = count_q != '0;
    assign count_o   = count_q;
    assign s_ready_o = ready_q;

endmodule

// ==== hdl/eth_tx_pkg.sv ====
package eth_tx_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [31:0] crc_t;

    // One end of the UDP link, as seen on the wire.
    typedef struct packed {
        mac_addr_t mac;
        ip_addr_t  ip;
        udp_port_t port;
    } endpoint_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame layout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int PREAMBLE_BYTES = 7;
    localparam int SFD_BYTES      = 1;
    localparam int HEADER_BYTES   = 42;
    localparam int FCS_BYTES      = 4;
    localparam int GAP_BYTES      = 12;

    // Ethernet, IPv4 and UDP headers back to back.
    // The first byte on the wire sits in the top bits.
    typedef logic [HEADER_BYTES*8-1:0] frame_header_t;

    localparam byte_t PREAMBLE_VAL = 8'h55;
    localparam byte_t SFD_VAL      = 8'hD5;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

    localparam byte_t IP_TTL       = 8'd64;
    localparam byte_t IP_PROTO_UDP = 8'd17;

endpackage
